/* rtl/memBusPkg.sv */
`default_nettype none

package memBusPkg;

    // one RAM cell
    localparam int ByteW = 8;

    // instruction and data words
    localparam int WordW = 32;

    // direction seen by the RAM
    typedef enum logic {
        Read  = 1'b0,
        Write = 1'b1
    } MemRw;

endpackage

`default_nettype wire

/* rtl/accessPkg.sv */
`default_nettype none

package accessPkg;

    // byte count of one access (1, 2 or 4)
    typedef logic [2:0] AccessLen;

    localparam AccessLen LenByte = 3'd1;
    localparam AccessLen LenHalf = 3'd2;
    localparam AccessLen LenWord = 3'd4;

    typedef enum logic {
        Load  = 1'b0,
        Store = 1'b1
    } LoadStore;

    // owner of the RAM while busy
    typedef enum logic [1:0] {
        Idle  = 2'd0,
        RInst = 2'd1,
        RData = 2'd2,
        WData = 2'd3
    } CtrlState;

endpackage

`default_nettype wire

/* rtl/byteRam.sv */
`timescale 1ns/1ps
`default_nettype none

module byteRam #(
    parameter int AddrWidth = 17
) (
    input  logic                        clk,
    input  logic [AddrWidth-1:0]        memAddr,
    input  memBusPkg::MemRw             memRw,
    input  logic [memBusPkg::ByteW-1:0] memWrByte,
    output logic [memBusPkg::ByteW-1:0] memRdByte
);

    logic [memBusPkg::ByteW-1:0] mem [2**AddrWidth];

    initial begin
        for (int i = 0; i < 2**AddrWidth; i++) begin
            mem[i] = '0;
        end
    end

    // read returns the old byte on a write to the same address
    always_ff @(posedge clk) begin
        if (memRw == memBusPkg::Write) begin
            mem[memAddr] <= memWrByte;
        end
        memRdByte <= mem[memAddr];
    end

endmodule

`default_nettype wire

/* rtl/memCtrl.sv */
`timescale 1ns/1ps
`default_nettype none

module memCtrl #(
    parameter int AddrWidth = 17
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        rdy,
    input  logic                        ioFull,

    // fetch client
    input  logic                        fetchEn,
    input  logic [AddrWidth-1:0]        fetchAddr,
    output logic                        fetchDone,
    output logic [memBusPkg::WordW-1:0] fetchWord,

    // data client
    input  logic                        dataEn,
    input  accessPkg::LoadStore         dataLs,
    input  accessPkg::AccessLen         dataLen,
    input  logic [AddrWidth-1:0]        dataAddr,
    input  logic [memBusPkg::WordW-1:0] dataWr,
    output logic                        dataDone,
    output logic [memBusPkg::WordW-1:0] dataRd,

    // RAM side
    output logic [AddrWidth-1:0]        memAddr,
    output memBusPkg::MemRw             memRw,
    output logic [memBusPkg::ByteW-1:0] memWrByte,
    input  logic [memBusPkg::ByteW-1:0] memRdByte
);

    localparam int ByteW = memBusPkg::ByteW;
    localparam int WordW = memBusPkg::WordW;

    accessPkg::CtrlState state;
    accessPkg::AccessLen len;
    logic [2:0]          stage;
    logic [AddrWidth-1:0] baseAddr;
    logic [WordW-1:0]    storeWord;
    logic [WordW-1:0]    asmWord;

    logic       stall;
    logic       lastStage;
    logic [2:0] prevStage;
    logic [2:0] addrOffset;

    assign stall     = !rdy || ioFull;
    assign lastStage = (state != accessPkg::Idle) && (stage == len);
    assign prevStage = stage - 3'd1;

    // a stalled cycle re-reads the byte still owed to the word register
    assign addrOffset = stall ? prevStage : stage;
    assign memAddr    = baseAddr + AddrWidth'(addrOffset);

    assign memRw = (state == accessPkg::WData && !lastStage && !stall) ?
                   memBusPkg::Write : memBusPkg::Read;
    assign memWrByte = storeWord[ByteW*stage[1:0] +: ByteW];

    // the last byte arrives from the RAM in the done cycle
    assign fetchDone = (state == accessPkg::RInst) && lastStage && !stall;
    assign dataDone  = (state == accessPkg::RData || state == accessPkg::WData) &&
                       lastStage && !stall;
    assign fetchWord = {memRdByte, asmWord[WordW-ByteW-1:0]};

    // zero-extended by access length
    always_comb begin
        case (len)
            accessPkg::LenByte: begin
                dataRd = {{(WordW-ByteW){1'b0}}, memRdByte};
            end
            accessPkg::LenHalf: begin
                dataRd = {{(WordW-2*ByteW){1'b0}}, memRdByte, asmWord[ByteW-1:0]};
            end
            default: begin
                dataRd = {memRdByte, asmWord[WordW-ByteW-1:0]};
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= accessPkg::Idle;
            stage <= 3'd0;
        end else if (!stall) begin
            case (state)
                accessPkg::Idle: begin
                    // data has priority over fetch
                    if (dataEn) begin
                        state <= (dataLs == accessPkg::Store) ?
                                 accessPkg::WData : accessPkg::RData;
                        stage <= 3'd0;
                    end else if (fetchEn) begin
                        state <= accessPkg::RInst;
                        stage <= 3'd0;
                    end
                end
                default: begin
                    if (lastStage) begin
                        state <= accessPkg::Idle;
                    end else begin
                        stage <= stage + 3'd1;
                    end
                end
            endcase
        end
    end

    // request payload and assembled bytes
    always_ff @(posedge clk) begin
        if (!stall) begin
            if (state == accessPkg::Idle) begin
                if (dataEn) begin
                    baseAddr  <= dataAddr;
                    len       <= dataLen;
                    storeWord <= dataWr;
                end else begin
                    baseAddr <= fetchAddr;
                    len      <= accessPkg::LenWord;
                end
            end else if (stage != 3'd0 && !lastStage) begin
                asmWord[ByteW*prevStage[1:0] +: ByteW] <= memRdByte;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/instFetch.sv */
`timescale 1ns/1ps
`default_nettype none

module instFetch #(
    parameter int          AddrWidth = 17,
    parameter int unsigned BootAddr  = 0
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        redirectEn,
    input  logic [AddrWidth-1:0]        redirectPc,
    output logic                        fetchEn,
    output logic [AddrWidth-1:0]        fetchAddr,
    input  logic                        fetchDone,
    input  logic [memBusPkg::WordW-1:0] fetchWord,
    input  logic                        qFree,
    output logic                        qPush,
    output logic [memBusPkg::WordW-1:0] qPushWord,
    output logic [memBusPkg::WordW-1:0] qPushPc,
    output logic                        qFlush
);

    logic [AddrWidth-1:0] pc;
    logic [AddrWidth-1:0] nextPc;
    logic [AddrWidth-1:0] reqAddr;
    logic                 reqActive;
    logic                 discard;
    logic                 issue;

    // a word fetched before a redirect never reaches the queue
    assign qPush     = fetchDone && !discard && !redirectEn;
    assign qPushWord = fetchWord;
    assign qPushPc   = memBusPkg::WordW'(reqAddr);
    assign qFlush    = redirectEn;

    assign fetchEn   = reqActive;
    assign fetchAddr = reqAddr;

    assign nextPc = redirectEn ? redirectPc :
                    qPush      ? pc + AddrWidth'(4) : pc;

    // qFree keeps a slot for the word returning in this cycle
    assign issue = (!reqActive || fetchDone) && qFree && !redirectEn;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc        <= AddrWidth'(BootAddr);
            reqActive <= 1'b0;
            discard   <= 1'b0;
        end else begin
            pc <= nextPc;
            if (issue) begin
                reqActive <= 1'b1;
            end else if (fetchDone) begin
                reqActive <= 1'b0;
            end
            // the controller cannot abort, so wait out the old fetch
            if (fetchDone) begin
                discard <= 1'b0;
            end else if (redirectEn && reqActive) begin
                discard <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            reqAddr <= nextPc;
        end
    end

endmodule

`default_nettype wire

/* rtl/instQueue.sv */
`timescale 1ns/1ps
`default_nettype none

module instQueue #(
    parameter int QueueDepth = 4
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        qFlush,
    input  logic                        qPush,
    input  logic [memBusPkg::WordW-1:0] qPushWord,
    input  logic [memBusPkg::WordW-1:0] qPushPc,
    output logic                        qFree,
    output logic                        instValid,
    output logic [memBusPkg::WordW-1:0] instWord,
    output logic [memBusPkg::WordW-1:0] instPc,
    input  logic                        instReady
);

    localparam int PtrW = $clog2(QueueDepth);

    logic [memBusPkg::WordW-1:0] wordMem [QueueDepth];
    logic [memBusPkg::WordW-1:0] pcMem [QueueDepth];
    logic [PtrW-1:0] wrPtr;
    logic [PtrW-1:0] rdPtr;
    logic [PtrW:0]   count;
    logic            doPush;
    logic            pop;

    assign doPush    = qPush && (count != (PtrW+1)'(QueueDepth));
    assign pop       = instValid && instReady;
    assign instValid = (count != '0);
    assign instWord  = wordMem[rdPtr];
    assign instPc    = pcMem[rdPtr];

    // one slot held back for a fetch already in flight
    assign qFree = (count < (PtrW+1)'(QueueDepth - 1));

    always_ff @(posedge clk) begin
        if (rst || qFlush) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            if (doPush && !pop) begin
                count <= count + 1'b1;
            end else if (!doPush && pop) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (doPush && !qFlush) begin
            wordMem[wrPtr] <= qPushWord;
            pcMem[wrPtr]   <= qPushPc;
        end
    end

endmodule

`default_nettype wire

/* rtl/memSubsys.sv */
`timescale 1ns/1ps
`default_nettype none

module memSubsys #(
    parameter int          AddrWidth  = 17,
    parameter int unsigned BootAddr   = 0,
    parameter int          QueueDepth = 4
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        rdy,
    input  logic                        ioFull,

    // data client
    input  logic                        dataEn,
    input  accessPkg::LoadStore         dataLs,
    input  accessPkg::AccessLen         dataLen,
    input  logic [AddrWidth-1:0]        dataAddr,
    input  logic [memBusPkg::WordW-1:0] dataWr,
    output logic                        dataDone,
    output logic [memBusPkg::WordW-1:0] dataRd,

    // instruction stream
    input  logic                        redirectEn,
    input  logic [AddrWidth-1:0]        redirectPc,
    output logic                        instValid,
    output logic [memBusPkg::WordW-1:0] instWord,
    output logic [memBusPkg::WordW-1:0] instPc,
    input  logic                        instReady
);

    // RAM bus
    logic [AddrWidth-1:0]        memAddr;
    memBusPkg::MemRw             memRw;
    logic [memBusPkg::ByteW-1:0] memWrByte;
    logic [memBusPkg::ByteW-1:0] memRdByte;

    // fetcher to controller
    logic                        fetchEn;
    logic [AddrWidth-1:0]        fetchAddr;
    logic                        fetchDone;
    logic [memBusPkg::WordW-1:0] fetchWord;

    // fetcher to queue
    logic                        qPush;
    logic [memBusPkg::WordW-1:0] qPushWord;
    logic [memBusPkg::WordW-1:0] qPushPc;
    logic                        qFlush;
    logic                        qFree;

    // all port names match the local nets
    byteRam #(
        .AddrWidth (AddrWidth)
    ) ram (.*);

    memCtrl #(
        .AddrWidth (AddrWidth)
    ) ctrl (.*);

    instFetch #(
        .AddrWidth (AddrWidth),
        .BootAddr  (BootAddr)
    ) fetch (.*);

    instQueue #(
        .QueueDepth (QueueDepth)
    ) queue (.*);

endmodule

`default_nettype wire

/* testbench/memSubsysTb.sv */
`timescale 1ns/1ps
`default_nettype none

module memSubsysTb;

    localparam int AddrWidth     = 17;
    localparam int unsigned BootAddr = 0;
    localparam int QueueDepth    = 4;
    localparam int MemSize       = 2**AddrWidth;
    localparam int AccessTimeout = 200;
    localparam int StreamTimeout = 1000;

    // data accesses stay clear of the fetched block
    localparam logic [AddrWidth-1:0] DataBase  = 17'h01000;
    localparam logic [AddrWidth-1:0] FetchBase = 17'h08000;

    logic                 clk;
    logic                 rst;
    logic                 rdy;
    logic                 ioFull;
    logic                 dataEn;
    accessPkg::LoadStore  dataLs;
    accessPkg::AccessLen  dataLen;
    logic [AddrWidth-1:0] dataAddr;
    logic [31:0]          dataWr;
    logic                 dataDone;
    logic [31:0]          dataRd;
    logic                 redirectEn;
    logic [AddrWidth-1:0] redirectPc;
    logic                 instValid;
    logic [31:0]          instWord;
    logic [31:0]          instPc;
    logic                 instReady;

    logic [7:0]  shadow [MemSize];
    logic [31:0] expPc;
    int          popCount;
    string       testName;
    bit          stallOn;
    int          readyMode;

    memSubsys #(
        .AddrWidth  (AddrWidth),
        .BootAddr   (BootAddr),
        .QueueDepth (QueueDepth)
    ) DUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // zero-extended little-endian word from the shadow array
    function automatic logic [31:0] expectedWord(input logic [AddrWidth-1:0] addr,
                                                 input int len);
        logic [31:0]          word;
        logic [AddrWidth-1:0] a;
        word = '0;
        for (int i = 0; i < len; i++) begin
            a = addr + AddrWidth'(i);
            word[8*i +: 8] = shadow[a];
        end
        return word;
    endfunction

    function automatic accessPkg::AccessLen pickLen();
        case ($urandom % 3)
            0: return accessPkg::LenByte;
            1: return accessPkg::LenHalf;
            default: return accessPkg::LenWord;
        endcase
    endfunction

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic checkEq(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual) begin
            abortRun($sformatf("ERR %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    // runs one data access and returns the cycles from acceptance to dataDone
    task automatic doAccess(input accessPkg::LoadStore ls, input accessPkg::AccessLen len,
                            input logic [AddrWidth-1:0] addr, input logic [31:0] wr,
                            output int lat);
        int                   waited;
        logic [AddrWidth-1:0] a;
        @(posedge clk);
        dataEn   <= 1'b1;
        dataLs   <= ls;
        dataLen  <= len;
        dataAddr <= addr;
        dataWr   <= wr;
        waited = 0;
        @(negedge clk);
        while (!dataDone) begin
            waited++;
            if (waited > AccessTimeout) begin
                abortRun("timeout: a data access never got dataDone");
            end
            @(negedge clk);
        end
        lat = waited;
        if (ls == accessPkg::Store) begin
            for (int i = 0; i < int'(len); i++) begin
                a = addr + AddrWidth'(i);
                shadow[a] = wr[8*i +: 8];
            end
        end
        @(posedge clk);
        dataEn <= 1'b0;
    endtask

    task automatic redirectTo(input logic [AddrWidth-1:0] target);
        @(posedge clk);
        redirectEn <= 1'b1;
        redirectPc <= target;
        @(posedge clk);
        redirectEn <= 1'b0;
    endtask

    task automatic waitPops(input int n);
        int target;
        int waited;
        target = popCount + n;
        waited = 0;
        while (popCount < target) begin
            @(posedge clk);
            waited++;
            if (waited > StreamTimeout) begin
                abortRun("timeout: the instruction stream stopped delivering words");
            end
        end
    endtask

    // waits until the queue is full and no fetch is pending
    task automatic waitFetchIdle();
        int waited;
        int idleRun;
        waited = 0;
        idleRun = 0;
        while (idleRun < 3) begin
            @(negedge clk);
            idleRun = (!DUT.fetchEn && instValid) ? idleRun + 1 : 0;
            waited++;
            if (waited > AccessTimeout) begin
                abortRun("timeout: the fetcher never went idle with the queue full");
            end
        end
    endtask

    // stall and back-pressure pattern
    initial begin
        rdy = 1'b1;
        ioFull = 1'b0;
        instReady = 1'b0;
        forever begin
            @(posedge clk);
            rdy    <= stallOn ? (($urandom % 4) != 0) : 1'b1;
            ioFull <= stallOn ? (($urandom % 6) == 0) : 1'b0;
            case (readyMode)
                0: instReady <= 1'b0;
                1: instReady <= 1'b1;
                default: instReady <= 1'($urandom % 2);
            endcase
        end
    end

    // compares every load result and every accepted instruction
    always @(negedge clk) begin
        if (rst) begin
            expPc = 32'(BootAddr);
        end else begin
            if (dataDone && dataLs == accessPkg::Load) begin
                checkEq({testName, " load"}, expectedWord(dataAddr, int'(dataLen)), dataRd);
            end
            if (redirectEn) begin
                expPc = 32'(redirectPc);
            end else if (instValid && instReady) begin
                checkEq({testName, " pc"}, expPc, instPc);
                checkEq({testName, " word"}, expectedWord(expPc[AddrWidth-1:0], 4), instWord);
                expPc = expPc + 32'd4;
                popCount++;
            end
        end
    end

    initial begin
        int                   lat;
        logic [AddrWidth-1:0] addr;
        accessPkg::AccessLen  len;
        void'($urandom(32'haa7c_de4f));
        for (int i = 0; i < MemSize; i++) begin
            shadow[i] = 8'h00;
        end
        popCount = 0;
        stallOn = 1'b0;
        readyMode = 0;
        testName = "reset";
        rst = 1'b1;
        dataEn = 1'b0;
        dataLs = accessPkg::Load;
        dataLen = accessPkg::LenWord;
        dataAddr = '0;
        dataWr = '0;
        redirectEn = 1'b0;
        redirectPc = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        repeat (3) begin
            @(negedge clk);
            checkEq("reset dataDone", 32'd0, 32'(dataDone));
            checkEq("reset instValid", 32'd0, 32'(instValid));
        end

        testName = "store load";
        for (int i = 0; i < 40; i++) begin
            addr = DataBase + AddrWidth'($urandom % 256);
            doAccess(accessPkg::Store, pickLen(), addr, $urandom, lat);
        end
        for (int i = 0; i < 40; i++) begin
            addr = DataBase + AddrWidth'($urandom % 256);
            doAccess(accessPkg::Load, pickLen(), addr, 32'd0, lat);
        end

        testName = "fetch stream";
        for (int i = 0; i < 16; i++) begin
            doAccess(accessPkg::Store, accessPkg::LenWord, FetchBase + AddrWidth'(4 * i),
                     $urandom, lat);
        end
        readyMode = 1;
        redirectTo(FetchBase);
        waitPops(12);

        testName = "back-pressure";
        readyMode = 2;
        waitPops(20);

        testName = "stalls";
        stallOn = 1'b1;
        redirectTo(FetchBase + 17'h00010);
        for (int i = 0; i < 30; i++) begin
            addr = DataBase + AddrWidth'($urandom % 256);
            doAccess(accessPkg::LoadStore'($urandom % 2), pickLen(), addr, $urandom, lat);
        end
        waitPops(8);
        stallOn = 1'b0;

        testName = "latency";
        readyMode = 0;
        waitFetchIdle();
        for (int i = 0; i < 12; i++) begin
            len = pickLen();
            addr = DataBase + AddrWidth'($urandom % 256);
            doAccess(accessPkg::LoadStore'($urandom % 2), len, addr, $urandom, lat);
            checkEq(testName, 32'(len) + 32'd1, 32'(lat));
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

/* memSubsys.f */
rtl/memBusPkg.sv
rtl/accessPkg.sv
rtl/byteRam.sv
rtl/memCtrl.sv
rtl/instFetch.sv
rtl/instQueue.sv
rtl/memSubsys.sv
testbench/memSubsysTb.sv
